/* files.f */
rtl/sudoku_pkg.sv
rtl/game_pkg.sv
rtl/button_pulse.sv
rtl/puzzle_apb_regs.sv
rtl/cursor_nav.sv
rtl/game_sequencer.sv
rtl/board_updater.sv
rtl/sudoku_top.sv
verif/tb_sudoku.sv

/* rtl/board_updater.sv */
module board_updater #(
    parameter int MAX_STRIKES = 3
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [game_pkg::BTN_VEC_W-1:0]     presses,
    input  game_pkg::game_state_t              state,
    input  logic [sudoku_pkg::CELL_IDX_W-1:0]  cursor,
    input  logic [sudoku_pkg::BOARD_W-1:0]     load_map,
    input  logic [sudoku_pkg::VIS_BOARD_W-1:0] load_visibility,
    output logic [sudoku_pkg::BOARD_W-1:0]     board,
    output logic [sudoku_pkg::VIS_BOARD_W-1:0] visibilities,
    output logic                               error,
    output logic [game_pkg::STRIKE_W-1:0]      strikes,
    output logic [sudoku_pkg::VALUE_W-1:0]     selected_number,
    output logic                               solved
);
    import sudoku_pkg::*;
    import game_pkg::*;

    localparam logic [STRIKE_W-1:0] STRIKE_LIMIT = STRIKE_W'(MAX_STRIKES);

    logic [BOARD_W-1:0]     board_next;
    logic [VIS_BOARD_W-1:0] vis_next;
    logic                   error_next;
    logic [STRIKE_W-1:0]    strikes_next;
    logic [VALUE_W-1:0]     number_next;
    logic [VALUE_W-1:0]     cell_digit;
    logic [VIS_W-1:0]       cell_vis;

    function automatic logic all_correct(input logic [VIS_BOARD_W-1:0] vis);
        logic ok;
        ok = 1'b1;
        for (int k = 0; k < CELL_COUNT; k++) begin
            ok = ok & (vis[VIS_W*k +: VIS_W] == VIS_CORRECT);
        end
        return ok;
    endfunction

    assign cell_digit = board[VALUE_W*cursor +: VALUE_W];
    assign cell_vis   = visibilities[VIS_W*cursor +: VIS_W];

    always_comb begin
        board_next   = board;
        vis_next     = visibilities;
        error_next   = error;
        strikes_next = strikes;
        number_next  = selected_number;

        case (state)
            GAME_LOADING: begin
                board_next   = load_map;
                vis_next     = load_visibility;
                error_next   = 1'b0;
                strikes_next = '0;
                number_next  = DIGIT_MIN;
            end
            GAME_PLAYING: begin
                // Only hidden cells get marked, so a solved cell keeps its code.
                if (cell_vis == VIS_HIDDEN) begin
                    vis_next[VIS_W*cursor +: VIS_W] = VIS_VISITED;
                end

                if (|presses) begin
                    error_next = 1'b0; // b has no other effect than this.
                end

                if (presses[BTN_UP]) begin
                    number_next = (selected_number >= DIGIT_MAX) ? DIGIT_MIN
                                                                 : selected_number + 1'b1;
                end else if (presses[BTN_DOWN]) begin
                    number_next = (selected_number <= DIGIT_MIN) ? DIGIT_MAX
                                                                 : selected_number - 1'b1;
                end

                if (presses[BTN_A] && cell_vis != VIS_CORRECT) begin
                    if (cell_digit == selected_number) begin
                        vis_next[VIS_W*cursor +: VIS_W] = VIS_CORRECT;
                    end else begin
                        vis_next[VIS_W*cursor +: VIS_W] = VIS_WRONG;
                        error_next = 1'b1;
                        if (strikes < STRIKE_LIMIT) begin
                            strikes_next = strikes + 1'b1;
                        end
                    end
                end
            end
            default: begin
                board_next = board;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            board           <= '0;
            visibilities    <= '0;
            error           <= 1'b0;
            strikes         <= '0;
            selected_number <= DIGIT_MIN;
            solved          <= 1'b0;
        end else begin
            board           <= board_next;
            visibilities    <= vis_next;
            error           <= error_next;
            strikes         <= strikes_next;
            selected_number <= number_next;
            // Taken from the next board so that a fresh load is judged at once.
            solved          <= all_correct(vis_next);
        end
    end

endmodule

/* rtl/button_pulse.sv */
module button_pulse #(
    parameter int BUTTON_COUNT = 6
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [BUTTON_COUNT-1:0] levels,
    output logic [BUTTON_COUNT-1:0] presses
);

    logic [BUTTON_COUNT-1:0] levels_q;

    // The levels are already synchronous to clk, so one stage of history is
    // enough to find the rising edge.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            levels_q <= '0;
            presses  <= '0;
        end else begin
            levels_q <= levels;
            presses  <= levels & ~levels_q; // Held buttons give a single press.
        end
    end

endmodule

/* rtl/cursor_nav.sv */
module cursor_nav (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [game_pkg::BTN_VEC_W-1:0]    presses,
    input  game_pkg::game_state_t             state,
    output logic [sudoku_pkg::CELL_IDX_W-1:0] cursor
);
    import sudoku_pkg::*;
    import game_pkg::*;

    localparam logic [CELL_IDX_W-1:0] LAST_CELL = CELL_IDX_W'(CELL_COUNT - 1);

    logic [CELL_IDX_W-1:0] cursor_next;

    always_comb begin
        cursor_next = cursor;
        case (state)
            GAME_LOADING: begin
                cursor_next = '0;
            end
            GAME_PLAYING: begin
                // Left has priority when both arrive in the same cycle.
                if (presses[BTN_LEFT]) begin
                    cursor_next = (cursor == '0) ? LAST_CELL : cursor - 1'b1;
                end else if (presses[BTN_RIGHT]) begin
                    cursor_next = (cursor == LAST_CELL) ? '0 : cursor + 1'b1;
                end
            end
            default: begin
                cursor_next = cursor;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cursor <= '0;
        end else begin
            cursor <= cursor_next;
        end
    end

endmodule

/* rtl/game_pkg.sv */
package game_pkg;

    localparam int STATE_W  = 3;
    localparam int STRIKE_W = 2;

    typedef enum logic [STATE_W-1:0] {
        GAME_IDLE    = 3'd0,
        GAME_LOADING = 3'd1,
        GAME_PLAYING = 3'd2,
        GAME_LOST    = 3'd3,
        GAME_WON     = 3'd4
    } game_state_t;

    localparam int BTN_VEC_W = 6;
    localparam int BTN_UP    = 0;
    localparam int BTN_DOWN  = 1;
    localparam int BTN_LEFT  = 2;
    localparam int BTN_RIGHT = 3;
    localparam int BTN_A     = 4;
    localparam int BTN_B     = 5;

    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;

    localparam logic [APB_ADDR_W-1:0] REG_CTRL      = 12'h000;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS    = 12'h004;
    localparam logic [APB_ADDR_W-1:0] REG_CELL_BASE = 12'h200;

    localparam int CTRL_START_BIT  = 0;
    localparam int CELL_VIS_LSB    = 4; // Digit sits in bits 3:0 of a cell word.
    localparam int STAT_STATE_LSB  = 0;
    localparam int STAT_STRIKE_LSB = 3;
    localparam int STAT_ERROR_BIT  = 5;
    localparam int STAT_NUMBER_LSB = 8;
    localparam int STAT_CURSOR_LSB = 16;

endpackage

/* rtl/game_sequencer.sv */
module game_sequencer #(
    parameter int MAX_STRIKES = 3
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic [game_pkg::STRIKE_W-1:0] strikes,
    input  logic                          solved,
    output game_pkg::game_state_t         state
);
    import game_pkg::*;

    localparam logic [STRIKE_W-1:0] STRIKE_LIMIT = STRIKE_W'(MAX_STRIKES);

    game_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            GAME_IDLE, GAME_LOST, GAME_WON: begin
                if (start) begin
                    state_next = GAME_LOADING;
                end
            end
            GAME_LOADING: begin
                state_next = GAME_PLAYING; // The load image is copied in this single cycle.
            end
            GAME_PLAYING: begin
                // A loss outranks a win on the same cycle.
                if (strikes == STRIKE_LIMIT) begin
                    state_next = GAME_LOST;
                end else if (solved) begin
                    state_next = GAME_WON;
                end
            end
            default: begin
                state_next = GAME_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= GAME_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* rtl/puzzle_apb_regs.sv */
module puzzle_apb_regs (
    input  logic                                clk,
    input  logic                                reset,

    input  logic [game_pkg::APB_ADDR_W-1:0]     paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [game_pkg::APB_DATA_W-1:0]     pwdata,
    output logic [game_pkg::APB_DATA_W-1:0]     prdata,
    output logic                                pready,
    output logic                                pslverr,

    input  game_pkg::game_state_t               state,
    input  logic [sudoku_pkg::BOARD_W-1:0]      board,
    input  logic [sudoku_pkg::VIS_BOARD_W-1:0]  visibilities,
    input  logic                                error,
    input  logic [game_pkg::STRIKE_W-1:0]       strikes,
    input  logic [sudoku_pkg::VALUE_W-1:0]      selected_number,
    input  logic [sudoku_pkg::CELL_IDX_W-1:0]   cursor,

    output logic                                start,
    output logic [sudoku_pkg::BOARD_W-1:0]      load_map,
    output logic [sudoku_pkg::VIS_BOARD_W-1:0]  load_visibility
);
    import sudoku_pkg::*;
    import game_pkg::*;

    localparam logic [APB_ADDR_W-1:0] CELL_END = REG_CELL_BASE + APB_ADDR_W'(4 * CELL_COUNT);

    logic                  access;
    logic                  is_ctrl;
    logic                  is_status;
    logic                  is_cell;
    logic                  addr_ok;
    logic                  load_open;
    logic [APB_ADDR_W-1:0] cell_offset;
    logic [CELL_IDX_W-1:0] cell_idx;
    logic [APB_DATA_W-1:0] status_word;
    logic [APB_DATA_W-1:0] cell_word;
    logic [APB_DATA_W-1:0] read_word;

    // Zero-wait slave, every transfer completes on the access edge.
    assign pready = 1'b1;
    assign access = psel & penable;

    assign is_ctrl     = (paddr == REG_CTRL);
    assign is_status   = (paddr == REG_STATUS);
    assign cell_offset = paddr - REG_CELL_BASE;
    assign cell_idx    = cell_offset[CELL_IDX_W+1:2];
    assign is_cell     = (paddr >= REG_CELL_BASE) && (paddr < CELL_END) && (paddr[1:0] == 2'b00);
    assign addr_ok     = is_ctrl | is_status | is_cell;

    // The load image may only change while no game is running.
    assign load_open = (state == GAME_IDLE) || (state == GAME_LOST) || (state == GAME_WON);

    assign start   = access & pwrite & is_ctrl & pwdata[CTRL_START_BIT];
    assign pslverr = access & (~addr_ok | (pwrite & is_status)); // STATUS is read-only.

    always_comb begin
        status_word = '0;
        status_word[STAT_STATE_LSB +: STATE_W]     = state;
        status_word[STAT_STRIKE_LSB +: STRIKE_W]   = strikes;
        status_word[STAT_ERROR_BIT]                = error;
        status_word[STAT_NUMBER_LSB +: VALUE_W]    = selected_number;
        status_word[STAT_CURSOR_LSB +: CELL_IDX_W] = cursor;
    end

    always_comb begin
        cell_word = '0;
        cell_word[VALUE_W-1:0]            = board[VALUE_W*cell_idx +: VALUE_W];
        cell_word[CELL_VIS_LSB +: VIS_W]  = visibilities[VIS_W*cell_idx +: VIS_W];
    end

    always_comb begin
        if (is_status) begin
            read_word = status_word;
        end else if (is_cell) begin
            read_word = cell_word;
        end else begin
            read_word = '0; // CTRL reads back as zero.
        end
    end

    assign prdata = (access && !pwrite && addr_ok) ? read_word : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_map        <= '0;
            load_visibility <= '0;
        end else if (access && pwrite && is_cell && load_open) begin
            load_map[VALUE_W*cell_idx +: VALUE_W]      <= pwdata[VALUE_W-1:0];
            load_visibility[VIS_W*cell_idx +: VIS_W]   <= pwdata[CELL_VIS_LSB +: VIS_W];
        end
    end

endmodule

/* rtl/sudoku_pkg.sv */
package sudoku_pkg;

    localparam int CELL_COUNT  = 81;
    localparam int CELL_IDX_W  = 7;
    localparam int VALUE_W     = 4;
    localparam int VIS_W       = 2;

    // Cell k holds its digit at bits 4k upward and its visibility at bits 2k upward.
    localparam int BOARD_W     = CELL_COUNT * VALUE_W;
    localparam int VIS_BOARD_W = CELL_COUNT * VIS_W;

    localparam logic [VIS_W-1:0] VIS_HIDDEN  = 2'd0; // Not yet seen.
    localparam logic [VIS_W-1:0] VIS_VISITED = 2'd1; // Seen by the cursor.
    localparam logic [VIS_W-1:0] VIS_WRONG   = 2'd2; // Last guess missed.
    localparam logic [VIS_W-1:0] VIS_CORRECT = 2'd3; // Solved or given.

    localparam logic [VALUE_W-1:0] DIGIT_MIN = 4'd1;
    localparam logic [VALUE_W-1:0] DIGIT_MAX = 4'd9;

endpackage

/* rtl/sudoku_top.sv */
module sudoku_top #(
    parameter int MAX_STRIKES  = 3,
    parameter int BUTTON_COUNT = 6
) (
    input  logic                            clk,
    input  logic                            reset,

    input  logic [game_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [game_pkg::APB_DATA_W-1:0] pwdata,
    output logic [game_pkg::APB_DATA_W-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,

    input  logic [BUTTON_COUNT-1:0]         buttons
);
    import sudoku_pkg::*;
    import game_pkg::*;

    logic [BUTTON_COUNT-1:0] presses;
    logic                    start;
    logic [BOARD_W-1:0]      load_map;
    logic [VIS_BOARD_W-1:0]  load_visibility;
    game_state_t             state;
    logic [CELL_IDX_W-1:0]   cursor;
    logic [BOARD_W-1:0]      board;
    logic [VIS_BOARD_W-1:0]  visibilities;
    logic                    error;
    logic [STRIKE_W-1:0]     strikes;
    logic [VALUE_W-1:0]      selected_number;
    logic                    solved;

    button_pulse #(
        .BUTTON_COUNT (BUTTON_COUNT)
    ) u_button_pulse (
        .clk     (clk),
        .reset   (reset),
        .levels  (buttons),
        .presses (presses)
    );

    puzzle_apb_regs u_puzzle_apb_regs (
        .clk             (clk),
        .reset           (reset),
        .paddr           (paddr),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .state           (state),
        .board           (board),
        .visibilities    (visibilities),
        .error           (error),
        .strikes         (strikes),
        .selected_number (selected_number),
        .cursor          (cursor),
        .start           (start),
        .load_map        (load_map),
        .load_visibility (load_visibility)
    );

    cursor_nav u_cursor_nav (
        .clk     (clk),
        .reset   (reset),
        .presses (presses),
        .state   (state),
        .cursor  (cursor)
    );

    game_sequencer #(
        .MAX_STRIKES (MAX_STRIKES)
    ) u_game_sequencer (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .strikes (strikes),
        .solved  (solved),
        .state   (state)
    );

    board_updater #(
        .MAX_STRIKES (MAX_STRIKES)
    ) u_board_updater (
        .clk             (clk),
        .reset           (reset),
        .presses         (presses),
        .state           (state),
        .cursor          (cursor),
        .load_map        (load_map),
        .load_visibility (load_visibility),
        .board           (board),
        .visibilities    (visibilities),
        .error           (error),
        .strikes         (strikes),
        .selected_number (selected_number),
        .solved          (solved)
    );

endmodule

/* verif/tb_sudoku.sv */
module tb_sudoku;
    timeunit 1ns;
    timeprecision 1ps;
    import sudoku_pkg::*;
    import game_pkg::*;

    localparam int MAX_STRIKES  = 3;
    localparam int BUTTON_COUNT = 6;
    localparam int CYCLE_LIMIT  = 20000;

    logic                    clk = 1'b0;
    logic                    reset;
    logic [11:0]             paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;
    logic [BUTTON_COUNT-1:0] buttons;

    // Expected game, kept apart from the DUT and advanced press by press.
    logic [3:0]  ld_digit [CELL_COUNT];
    logic [1:0]  ld_vis [CELL_COUNT];
    logic [3:0]  m_digit [CELL_COUNT];
    logic [1:0]  m_vis [CELL_COUNT];
    game_state_t m_state;
    int          m_strikes;
    logic        m_error;
    int          m_number;
    int          m_cursor;

    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          k;
    int          k2;
    int          guess;
    logic        err;
    logic [31:0] data;

    sudoku_top #(
        .MAX_STRIKES  (MAX_STRIKES),
        .BUTTON_COUNT (BUTTON_COUNT)
    ) u_sudoku_top (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .buttons (buttons)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic void model_visit();
        if (m_vis[m_cursor] == VIS_HIDDEN) begin
            m_vis[m_cursor] = VIS_VISITED;
        end
    endfunction

    function automatic void model_judge();
        int solved_cells;
        solved_cells = 0;
        for (int i = 0; i < CELL_COUNT; i++) begin
            if (m_vis[i] == VIS_CORRECT) begin
                solved_cells++;
            end
        end
        if (m_strikes == MAX_STRIKES) begin
            m_state = GAME_LOST; // A loss is judged before a win.
        end else if (solved_cells == CELL_COUNT) begin
            m_state = GAME_WON;
        end
    endfunction

    function automatic void model_start();
        for (int i = 0; i < CELL_COUNT; i++) begin
            m_digit[i] = ld_digit[i];
            m_vis[i]   = ld_vis[i];
        end
        m_error   = 1'b0;
        m_strikes = 0;
        m_number  = 1;
        m_cursor  = 0;
        m_state   = GAME_PLAYING;
        model_visit();
        model_judge();
    endfunction

    function automatic void model_press(input int btn);
        if (m_state != GAME_PLAYING) begin
            return;
        end
        m_error = 1'b0;
        if (btn == BTN_UP) begin
            m_number = (m_number == 9) ? 1 : m_number + 1;
        end else if (btn == BTN_DOWN) begin
            m_number = (m_number == 1) ? 9 : m_number - 1;
        end else if (btn == BTN_LEFT) begin
            m_cursor = (m_cursor == 0) ? CELL_COUNT - 1 : m_cursor - 1;
        end else if (btn == BTN_RIGHT) begin
            m_cursor = (m_cursor == CELL_COUNT - 1) ? 0 : m_cursor + 1;
        end else if (btn == BTN_A && m_vis[m_cursor] != VIS_CORRECT) begin
            if (m_digit[m_cursor] == m_number) begin
                m_vis[m_cursor] = VIS_CORRECT;
            end else begin
                m_vis[m_cursor] = VIS_WRONG;
                m_error = 1'b1;
                if (m_strikes < MAX_STRIKES) begin
                    m_strikes++;
                end
            end
        end
        model_visit();
        model_judge();
    endfunction

    function automatic logic [31:0] expected_status();
        logic [31:0] word;
        word = '0;
        word[2:0]   = m_state;
        word[4:3]   = m_strikes[1:0];
        word[5]     = m_error;
        word[11:8]  = m_number[3:0];
        word[22:16] = m_cursor[6:0];
        return word;
    endfunction

    function automatic logic [31:0] expected_cell(input int idx);
        logic [31:0] word;
        word = '0;
        word[3:0] = m_digit[idx];
        word[5:4] = m_vis[idx];
        return word;
    endfunction

    function automatic int first_open_cell(input int from);
        int found;
        found = -1;
        for (int i = CELL_COUNT - 1; i >= from; i--) begin
            if (m_vis[i] != VIS_CORRECT) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata,
                             output logic slverr);
        @(posedge clk);
        paddr   <= addr;
        pwdata  <= wdata;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        slverr = pslverr;
        if (pready !== 1'b1) begin
            $display("The slave held pready low in a write access phase at %0t", $time);
            errors++;
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata,
                            output logic slverr);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk); // Read data is combinational in the access phase.
        rdata  = prdata;
        slverr = pslverr;
        if (pready !== 1'b1) begin
            $display("The slave held pready low in a read access phase at %0t", $time);
            errors++;
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_status();
        logic [31:0] rdata;
        logic        slverr;
        apb_read(REG_STATUS, rdata, slverr);
        checks++;
        if (slverr) begin
            $display("The STATUS read at %0t was answered with a slave error", $time);
            errors++;
        end
        if (rdata !== expected_status()) begin
            $display("** Error at %0t: STATUS read 0x%08h, expected 0x%08h",
                     $time, rdata, expected_status());
            errors++;
        end
    endtask

    task automatic check_cell(input int idx);
        logic [31:0] rdata;
        logic        slverr;
        apb_read(REG_CELL_BASE + 12'(4 * idx), rdata, slverr);
        checks++;
        if (slverr) begin
            $display("The read of cell %0d at %0t was answered with a slave error", idx, $time);
            errors++;
        end
        if (rdata !== expected_cell(idx)) begin
            $display("** Error at %0t: cell %0d read 0x%08h, expected 0x%08h",
                     $time, idx, rdata, expected_cell(idx));
            errors++;
        end
    endtask

    task automatic check_board();
        for (int i = 0; i < CELL_COUNT; i++) begin
            check_cell(i);
        end
        check_status();
    endtask

    task automatic press_button(input int btn);
        @(posedge clk);
        buttons <= 6'(1 << btn);
        @(posedge clk);
        buttons <= '0;
        repeat (4) @(posedge clk);
        model_press(btn);
        check_status();
        check_cell(m_cursor);
    endtask

    task automatic move_to(input int target);
        while (m_cursor != target && m_state == GAME_PLAYING) begin
            press_button(BTN_RIGHT);
        end
    endtask

    task automatic select_number(input int number);
        while (m_number != number && m_state == GAME_PLAYING) begin
            press_button(BTN_UP);
        end
    endtask

    task automatic load_puzzle(input bit mostly_solved);
        logic slverr;
        for (int i = 0; i < CELL_COUNT; i++) begin
            ld_digit[i] = 4'(1 + $urandom % 9);
            if (mostly_solved) begin
                ld_vis[i] = ($urandom % 4 != 0) ? VIS_CORRECT : 2'($urandom % 3);
            end else begin
                ld_vis[i] = 2'($urandom % 4);
            end
            if (mostly_solved && i == 40) begin
                ld_vis[i] = VIS_VISITED; // At least one cell is left to guess.
            end
            apb_write(REG_CELL_BASE + 12'(4 * i), {26'd0, ld_vis[i], ld_digit[i]}, slverr);
            if (slverr) begin
                $display("The write of cell %0d at %0t raised a slave error", i, $time);
                errors++;
            end
        end
    endtask

    task automatic start_game();
        logic [31:0] rdata;
        logic        slverr;
        int          tries;
        apb_write(REG_CTRL, 32'd1, slverr);
        model_start();
        tries = 0;
        rdata = '0;
        while (rdata[2:0] != GAME_PLAYING && tries < 10) begin
            apb_read(REG_STATUS, rdata, slverr);
            tries++;
        end
        if (rdata[2:0] != GAME_PLAYING) begin
            $display("The game did not reach the playing state after start at %0t", $time);
            errors++;
        end
    endtask

    initial begin
        void'($urandom(29873));
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        buttons = '0;
        for (int i = 0; i < CELL_COUNT; i++) begin
            m_digit[i] = '0;
            m_vis[i]   = '0;
        end
        m_state   = GAME_IDLE;
        m_strikes = 0;
        m_error   = 1'b0;
        m_number  = 1;
        m_cursor  = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        check_status();

        $display("Test 1: load and readback");
        load_puzzle(1'b0);
        start_game();
        check_board();

        $display("Test 2: number selection");
        repeat (30) press_button(($urandom % 2) ? BTN_UP : BTN_DOWN);

        $display("Test 3: cursor and visiting");
        repeat (40) press_button(($urandom % 2) ? BTN_LEFT : BTN_RIGHT);
        check_board();

        $display("Test 4: guessing");
        k = first_open_cell(0);
        move_to(k);
        select_number(m_digit[k]);
        press_button(BTN_A);
        k2 = first_open_cell(0);
        guess = 1 + $urandom % 9;
        if (guess == m_digit[k2]) begin
            guess = (guess % 9) + 1;
        end
        move_to(k2);
        select_number(guess);
        press_button(BTN_A);
        press_button(BTN_B);
        check_board();

        $display("Test 6: APB errors");
        apb_read(12'h3F0, data, err);
        if (!err) begin
            $display("The read of unused offset 0x3F0 gave no slave error at %0t", $time);
            errors++;
        end
        apb_write(REG_STATUS, 32'hFFFF_FFFF, err);
        if (!err) begin
            $display("The write to STATUS gave no slave error at %0t", $time);
            errors++;
        end
        check_board();

        $display("Test 5: end of game");
        press_button(BTN_A); // Cell k2 still holds a wrong guess.
        press_button(BTN_A);
        apb_read(REG_STATUS, data, err);
        checks++;
        if (data[2:0] !== GAME_LOST) begin
            $display("** Error at %0t: state %0d after three wrong guesses, expected lost",
                     $time, data[2:0]);
            errors++;
        end
        press_button(BTN_UP);
        press_button(BTN_RIGHT);
        press_button(BTN_A);
        check_board();
        load_puzzle(1'b1);
        start_game();
        for (int i = 0; i < CELL_COUNT; i++) begin
            if (m_vis[i] != VIS_CORRECT && m_state == GAME_PLAYING) begin
                move_to(i);
                select_number(m_digit[i]);
                press_button(BTN_A);
            end
        end
        apb_read(REG_STATUS, data, err);
        checks++;
        if (data[2:0] !== GAME_WON) begin
            $display("** Error at %0t: state %0d after solving every cell, expected won",
                     $time, data[2:0]);
            errors++;
        end
        check_board();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
